//--- Bender.yml
package:
  name: exu

sources:
  - common/exu_pkg.sv
  - exu/exu_alu.sv
  - exu/exu_bypass.sv
  - exu/exu_csr_ops.sv
  - exu/exu_stage.sv
  - rtl/exu_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_exu_top.sv

//--- common/exu_pkg.sv
package exu_pkg;

    localparam int XLEN         = 32;
    localparam int BYPASS_DEPTH = 4;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [3:0]      reg_idx_t;  // RV32E has x0..x15.
    typedef logic [11:0]     csr_addr_t;

    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    ////////////////////
    // Enums
    ////////////////////

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B,  // Lui.
        ALU_EQ,      // Compare group from here on.
        ALU_NE,
        ALU_LT,
        ALU_GE,
        ALU_LTU,
        ALU_GEU
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_e;

    ////////////////////
    // Bundles
    ////////////////////

    typedef struct packed {
        xlen_t     pc;
        xlen_t     imm;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        xlen_t     src1_r;
        xlen_t     src2_r;
        alu_op_e   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      is_jump;
        logic      is_load;
        logic      is_store;
        mem_size_e load_size;
        mem_size_e store_size;
        logic      gpr_we;
        logic      csrrw_op;
        logic      csrrs_op;
        xlen_t     csr_data;   // Old CSR value.
        logic      ecall;
        logic      mret;
        logic      ebreak;
        logic      fence_i;
    } du_to_eu_t;

    typedef struct packed {
        logic mtvec;
        logic mepc;
        logic mstatus;
        logic mcause;
    } csr_wen_t;

    typedef struct packed {
        xlen_t     pc;
        reg_idx_t  rd;
        logic      gpr_we;
        logic      is_load;
        logic      is_store;
        mem_size_e load_size;
        mem_size_e store_size;
        xlen_t     result;     // Value bound for rd.
        xlen_t     store_data;
        csr_wen_t  csr_wen;
        xlen_t     csr_wdata;
        logic      ecall;
        logic      mret;
    } eu_to_lu_t;

endpackage

//--- exu/exu_alu.sv
`timescale 1ns/1ps

module exu_alu (
    input  exu_pkg::alu_op_e op,
    input  exu_pkg::xlen_t   a,
    input  exu_pkg::xlen_t   b,
    input  exu_pkg::xlen_t   cmp_a,
    input  exu_pkg::xlen_t   cmp_b,
    output exu_pkg::xlen_t   result,
    output logic             cond
);

    logic [4:0]     shamt;
    exu_pkg::xlen_t sum;
    exu_pkg::xlen_t diff;
    logic           lt_s;
    logic           lt_u;
    logic           cmp_eq;
    logic           cmp_lt;
    logic           cmp_ltu;

    assign shamt = b[4:0];
    assign sum   = a + b;
    assign diff  = a - b;
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    ////////////////////
    // Function unit
    ////////////////////

    always_comb begin
        case (op)
            exu_pkg::ALU_ADD:    result = sum;
            exu_pkg::ALU_SUB:    result = diff;
            exu_pkg::ALU_SLL:    result = a << shamt;
            exu_pkg::ALU_SLT:    result = {{(exu_pkg::XLEN-1){1'b0}}, lt_s};
            exu_pkg::ALU_SLTU:   result = {{(exu_pkg::XLEN-1){1'b0}}, lt_u};
            exu_pkg::ALU_XOR:    result = a ^ b;
            exu_pkg::ALU_SRL:    result = a >> shamt;
            exu_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
            exu_pkg::ALU_OR:     result = a | b;
            exu_pkg::ALU_AND:    result = a & b;
            exu_pkg::ALU_PASS_B: result = b;
            default:             result = sum;  // Branch target.
        endcase
    end

    ////////////////////
    // Branch compare
    ////////////////////

    assign cmp_eq  = (cmp_a == cmp_b);
    assign cmp_lt  = $signed(cmp_a) < $signed(cmp_b);
    assign cmp_ltu = cmp_a < cmp_b;

    always_comb begin
        case (op)
            exu_pkg::ALU_EQ:  cond = cmp_eq;
            exu_pkg::ALU_NE:  cond = ~cmp_eq;
            exu_pkg::ALU_LT:  cond = cmp_lt;
            exu_pkg::ALU_GE:  cond = ~cmp_lt;
            exu_pkg::ALU_LTU: cond = cmp_ltu;
            exu_pkg::ALU_GEU: cond = ~cmp_ltu;
            default:          cond = 1'b1;  // Unconditional.
        endcase
    end

endmodule

//--- exu/exu_bypass.sv
`timescale 1ns/1ps

module exu_bypass (
    input  logic              clk,
    input  logic              rst,
    input  exu_pkg::reg_idx_t rs1,
    input  exu_pkg::reg_idx_t rs2,
    input  exu_pkg::xlen_t    src1_r,
    input  exu_pkg::xlen_t    src2_r,
    output exu_pkg::xlen_t    src1,
    output exu_pkg::xlen_t    src2,
    output logic              stall,
    input  logic              push,
    input  exu_pkg::reg_idx_t push_rd,
    input  exu_pkg::xlen_t    push_data,
    input  logic              push_is_load,
    input  logic              fill,
    input  exu_pkg::xlen_t    fill_data
);

    typedef struct packed {
        exu_pkg::reg_idx_t rd;
        exu_pkg::xlen_t    data;
        logic              pending;  // Load result not back yet.
    } entry_t;

    typedef entry_t [exu_pkg::BYPASS_DEPTH-1:0] hist_t;

    typedef struct packed {
        exu_pkg::xlen_t data;
        logic           pending;
    } lookup_t;

    hist_t   hist;       // Index 0 is the newest write.
    hist_t   filled;
    entry_t  new_entry;
    lookup_t look1;
    lookup_t look2;

    // Walk oldest to newest so the newest match wins.
    function automatic lookup_t find(input hist_t h, input exu_pkg::reg_idx_t rs,
                                     input exu_pkg::xlen_t rf_val);
        lookup_t res;
        res.data    = rf_val;
        res.pending = 1'b0;
        for (int i = exu_pkg::BYPASS_DEPTH - 1; i >= 0; i--) begin
            if ((rs != '0) && (h[i].rd == rs)) begin
                res.data    = h[i].data;
                res.pending = h[i].pending;
            end
        end
        return res;
    endfunction

    assign look1 = find(hist, rs1, src1_r);
    assign look2 = find(hist, rs2, src2_r);
    assign src1  = look1.data;
    assign src2  = look2.data;
    assign stall = look1.pending | look2.pending;

    ////////////////////
    // History update
    ////////////////////

    always_comb begin
        filled = hist;
        for (int i = 0; i < exu_pkg::BYPASS_DEPTH; i++) begin
            if (fill && hist[i].pending) begin
                filled[i].data    = fill_data;
                filled[i].pending = 1'b0;
            end
        end
    end

    assign new_entry = '{rd: push_rd, data: push_data, pending: push_is_load};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist <= '0;
        end else if (push) begin
            hist <= {filled[exu_pkg::BYPASS_DEPTH-2:0], new_entry};  // Oldest drops out.
        end else begin
            hist <= filled;
        end
    end

endmodule

//--- exu/exu_csr_ops.sv
`timescale 1ns/1ps

module exu_csr_ops (
    input  exu_pkg::csr_addr_t csr_addr,
    input  logic               csrrw_op,
    input  logic               csrrs_op,
    input  exu_pkg::xlen_t     rs1_val,
    input  exu_pkg::xlen_t     csr_data,
    output exu_pkg::csr_wen_t  csr_wen,
    output exu_pkg::xlen_t     csr_wdata
);

    logic csr_op;

    assign csr_op = csrrw_op | csrrs_op;

    always_comb begin
        if (csrrs_op) begin
            csr_wdata = rs1_val | csr_data;  // Set bits.
        end else if (csrrw_op) begin
            csr_wdata = rs1_val;
        end else begin
            csr_wdata = '0;
        end
    end

    // Unknown addresses write nothing.
    assign csr_wen.mtvec   = csr_op && (csr_addr == exu_pkg::CSR_MTVEC);
    assign csr_wen.mepc    = csr_op && (csr_addr == exu_pkg::CSR_MEPC);
    assign csr_wen.mstatus = csr_op && (csr_addr == exu_pkg::CSR_MSTATUS);
    assign csr_wen.mcause  = csr_op && (csr_addr == exu_pkg::CSR_MCAUSE);

endmodule

//--- exu/exu_stage.sv
`timescale 1ns/1ps

module exu_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               idu_valid,
    input  exu_pkg::du_to_eu_t du_to_eu,
    output logic               exu_ready,
    input  logic               lsu_ready,
    output logic               exu_valid,
    output exu_pkg::eu_to_lu_t eu_to_lu,
    output logic               fence_i_req,
    input  logic               load_data_valid,
    input  exu_pkg::xlen_t     load_data,
    output logic               redirect_valid,
    output exu_pkg::xlen_t     redirect_pc,
    input  logic               pc_update,
    output logic               ebreak_hit
);

    exu_pkg::xlen_t     src1;
    exu_pkg::xlen_t     src2;
    exu_pkg::xlen_t     alu_a;
    exu_pkg::xlen_t     alu_b;
    exu_pkg::xlen_t     alu_result;
    exu_pkg::xlen_t     seq_pc;
    exu_pkg::xlen_t     exec_result;
    exu_pkg::xlen_t     wb_value;
    exu_pkg::xlen_t     target;
    exu_pkg::xlen_t     csr_wdata;
    exu_pkg::csr_wen_t  csr_wen;
    exu_pkg::eu_to_lu_t lu_next;
    logic               cond;
    logic               stall;
    logic               accept;
    logic               csr_op;
    logic               trap;
    logic               take_redirect;

    assign exu_ready = lsu_ready & ~stall;
    assign accept    = idu_valid & exu_ready & ~redirect_valid;  // Squash behind a redirect.
    assign csr_op    = du_to_eu.csrrw_op | du_to_eu.csrrs_op;
    assign trap      = du_to_eu.ecall | du_to_eu.mret;

    exu_bypass u_bypass (
        .clk          (clk),
        .rst          (rst),
        .rs1          (du_to_eu.rs1),
        .rs2          (du_to_eu.rs2),
        .src1_r       (du_to_eu.src1_r),
        .src2_r       (du_to_eu.src2_r),
        .src1         (src1),
        .src2         (src2),
        .stall        (stall),
        .push         (accept & du_to_eu.gpr_we),
        .push_rd      (du_to_eu.rd),
        .push_data    (wb_value),
        .push_is_load (du_to_eu.is_load),
        .fill         (load_data_valid),
        .fill_data    (load_data)
    );

    assign alu_a = du_to_eu.src1_is_pc  ? du_to_eu.pc  : src1;
    assign alu_b = du_to_eu.src2_is_imm ? du_to_eu.imm : src2;

    exu_alu u_alu (
        .op     (du_to_eu.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .cmp_a  (src1),
        .cmp_b  (src2),
        .result (alu_result),
        .cond   (cond)
    );

    exu_csr_ops u_csr_ops (
        .csr_addr  (du_to_eu.imm[11:0]),  // CSR number rides in the immediate.
        .csrrw_op  (du_to_eu.csrrw_op),
        .csrrs_op  (du_to_eu.csrrs_op),
        .rs1_val   (src1),
        .csr_data  (du_to_eu.csr_data),
        .csr_wen   (csr_wen),
        .csr_wdata (csr_wdata)
    );

    ////////////////////
    // Result and redirect
    ////////////////////

    assign seq_pc        = du_to_eu.pc + 32'd4;
    assign exec_result   = du_to_eu.is_jump ? seq_pc : alu_result;  // Link value.
    assign wb_value      = csr_op ? du_to_eu.csr_data : exec_result;
    assign target        = trap ? du_to_eu.csr_data : alu_result;
    assign take_redirect = (trap | (du_to_eu.is_jump & cond)) & (target != seq_pc);

    always_comb begin
        lu_next            = '0;
        lu_next.pc         = du_to_eu.pc;
        lu_next.rd         = du_to_eu.rd;
        lu_next.gpr_we     = du_to_eu.gpr_we;
        lu_next.is_load    = du_to_eu.is_load;
        lu_next.is_store   = du_to_eu.is_store;
        lu_next.load_size  = du_to_eu.load_size;
        lu_next.store_size = du_to_eu.store_size;
        lu_next.result     = wb_value;
        lu_next.store_data = src2;
        lu_next.csr_wen    = csr_wen;
        lu_next.csr_wdata  = csr_wdata;
        lu_next.ecall      = du_to_eu.ecall;
        lu_next.mret       = du_to_eu.mret;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exu_valid   <= 1'b0;
            fence_i_req <= 1'b0;
            eu_to_lu    <= '0;
        end else if (exu_ready) begin
            exu_valid   <= accept;
            fence_i_req <= accept & du_to_eu.fence_i;
            eu_to_lu    <= accept ? lu_next : '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end else if (redirect_valid) begin
            if (pc_update) begin
                redirect_valid <= 1'b0;  // Fetch has taken the new pc.
            end
        end else if (accept && take_redirect) begin
            redirect_valid <= 1'b1;
            redirect_pc    <= target;
        end
    end

    assign ebreak_hit = idu_valid & du_to_eu.ebreak & ~redirect_valid;

endmodule

//--- rtl/exu_top.sv
`timescale 1ns/1ps

module exu_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               idu_valid,
    input  exu_pkg::du_to_eu_t du_to_eu,
    output logic               exu_ready,
    input  logic               lsu_ready,
    output logic               exu_valid,
    output exu_pkg::eu_to_lu_t eu_to_lu,
    output logic               fence_i_req,
    input  logic               load_data_valid,
    input  exu_pkg::xlen_t     load_data,
    output logic               redirect_valid,
    output exu_pkg::xlen_t     redirect_pc,
    input  logic               pc_update,
    output logic               ebreak_hit
);

    exu_stage u_stage (
        .clk             (clk),
        .rst             (rst),
        .idu_valid       (idu_valid),
        .du_to_eu        (du_to_eu),
        .exu_ready       (exu_ready),
        .lsu_ready       (lsu_ready),
        .exu_valid       (exu_valid),
        .eu_to_lu        (eu_to_lu),
        .fence_i_req     (fence_i_req),     // To the I-cache.
        .load_data_valid (load_data_valid),
        .load_data       (load_data),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .pc_update       (pc_update),
        .ebreak_hit      (ebreak_hit)
    );

endmodule

//--- src.f
+incdir+verif
common/exu_pkg.sv
exu/exu_alu.sv
exu/exu_bypass.sv
exu/exu_csr_ops.sv
exu/exu_stage.sv
rtl/exu_top.sv
verif/tb_exu_top.sv

//--- verif/tb_exu_vectors.svh
// Row pc is 0x1000 + 4 * row index. Arguments of add_row are:
// instruction, idu_valid, fill, pc_update, ready, valid, csr_wen, redirect_valid, redirect_pc.

////////////////////
// ALU and immediates
////////////////////
add_row(op_imm(exu_pkg::ALU_ADD, 4'd1, 4'd0, 32'h0000_0123), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);
add_row(op_imm(exu_pkg::ALU_ADD, 4'd2, 4'd0, 32'hFFFF_FF85), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);
add_row(op_reg(exu_pkg::ALU_ADD, 4'd3, 4'd1, 4'd2), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);
add_row(op_reg(exu_pkg::ALU_SUB, 4'd4, 4'd1, 4'd2), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);
add_row(op_imm(exu_pkg::ALU_SLL, 4'd5, 4'd1, 32'h0000_0004), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);
add_row(op_imm(exu_pkg::ALU_SRA, 4'd6, 4'd2, 32'h0000_0003), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);
add_row(op_imm(exu_pkg::ALU_SRL, 4'd7, 4'd2, 32'h0000_0008), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);
add_row(op_reg(exu_pkg::ALU_SLT, 4'd8, 4'd2, 4'd1), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);
add_row(op_reg(exu_pkg::ALU_SLTU, 4'd9, 4'd2, 4'd1), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);
add_row(op_reg(exu_pkg::ALU_XOR, 4'd10, 4'd1, 4'd2), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);
add_row(op_imm(exu_pkg::ALU_OR, 4'd11, 4'd1, 32'h0000_00F0), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);
add_row(op_reg(exu_pkg::ALU_AND, 4'd12, 4'd1, 4'd2), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);
add_row(op_imm(exu_pkg::ALU_PASS_B, 4'd13, 4'd0, 32'hABCD_E000), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);

////////////////////
// Forwarding depth and x0
////////////////////
add_row(op_reg(exu_pkg::ALU_ADD, 4'd14, 4'd1, 4'd13), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);
add_row(op_imm(exu_pkg::ALU_ADD, 4'd0, 4'd14, 32'h0000_0005), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);
add_row(op_reg(exu_pkg::ALU_ADD, 4'd15, 4'd0, 4'd14), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);

////////////////////
// Load-use stall
////////////////////
add_row(load_word(4'd5, 4'd0, 32'h0000_0200), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);
add_row(blank(), 0, 0, 0, 1, 0, 4'h0, 0, 32'h0);
add_row(op_reg(exu_pkg::ALU_ADD, 4'd6, 4'd5, 4'd14), 1, 0, 0, 0, 0, 4'h0, 0, 32'h0);
add_row(op_reg(exu_pkg::ALU_ADD, 4'd6, 4'd5, 4'd14), 1, 1, 0, 0, 0, 4'h0, 0, 32'h0);
add_row(op_reg(exu_pkg::ALU_ADD, 4'd6, 4'd5, 4'd14), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0);

////////////////////
// Jumps and traps
////////////////////
add_row(branch(exu_pkg::ALU_EQ, 4'd3, 4'd3, 32'h40), 1, 0, 0, 1, 1, 4'h0, 1, 32'h1094);
add_row(op_imm(exu_pkg::ALU_ADD, 4'd1, 4'd0, 32'h7), 1, 0, 0, 1, 0, 4'h0, 1, 32'h1094);
add_row(blank(), 1, 0, 1, 1, 0, 4'h0, 0, 32'h1094);
add_row(branch(exu_pkg::ALU_NE, 4'd6, 4'd6, 32'h40), 1, 0, 0, 1, 1, 4'h0, 0, 32'h1094);
add_row(branch(exu_pkg::ALU_EQ, 4'd0, 4'd0, 32'h4), 1, 0, 0, 1, 1, 4'h0, 0, 32'h1094);
add_row(jal(4'd7, 32'h20), 1, 0, 0, 1, 1, 4'h0, 1, 32'h1088);
add_row(op_reg(exu_pkg::ALU_ADD, 4'd8, 4'd7, 4'd0), 1, 0, 1, 1, 0, 4'h0, 0, 32'h1088);
add_row(op_reg(exu_pkg::ALU_ADD, 4'd9, 4'd7, 4'd0), 1, 0, 0, 1, 1, 4'h0, 0, 32'h1088);
add_row(ecall(32'h0000_0800), 1, 0, 0, 1, 1, 4'h0, 1, 32'h0800);
add_row(blank(), 1, 0, 1, 1, 0, 4'h0, 0, 32'h0800);

////////////////////
// CSR ops and strobes
////////////////////
add_row(csr_op(0, 4'd10, 4'd9, exu_pkg::CSR_MTVEC, 32'h1111_0000), 1, 0, 0, 1, 1, 4'h8, 0,
        32'h0800);
add_row(csr_op(1, 4'd11, 4'd10, exu_pkg::CSR_MSTATUS, 32'h0000_0088), 1, 0, 0, 1, 1, 4'h2, 0,
        32'h0800);
add_row(csr_op(0, 4'd12, 4'd0, 12'h7C0, 32'h0000_0042), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0800);
add_row(side_op(1'b0, 1'b1), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0800);
add_row(side_op(1'b1, 1'b0), 1, 0, 0, 1, 1, 4'h0, 0, 32'h0800);
add_row(blank(), 0, 0, 0, 1, 0, 4'h0, 0, 32'h0800);

//--- verif/tb_exu_top.sv
`timescale 1ns/1ps

module tb_exu_top;

    typedef struct packed {
        exu_pkg::du_to_eu_t instr;
        logic               valid;
        logic               fill;
        exu_pkg::xlen_t     fill_data;
        logic               pc_upd;
        logic               e_ready;
        logic               e_valid;
        logic [3:0]         e_wen;
        logic               e_rv;
        exu_pkg::xlen_t     e_rpc;
    } row_t;

    logic               clk;
    logic               rst;
    logic               idu_valid;
    exu_pkg::du_to_eu_t du_to_eu;
    logic               exu_ready;
    logic               lsu_ready;
    logic               exu_valid;
    exu_pkg::eu_to_lu_t eu_to_lu;
    logic               fence_i_req;
    logic               load_data_valid;
    exu_pkg::xlen_t     load_data;
    logic               redirect_valid;
    exu_pkg::xlen_t     redirect_pc;
    logic               pc_update;
    logic               ebreak_hit;

    row_t        rows[$];
    logic [31:0] rng = 32'h2c5e_127c;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycle_limit = 10000;

    // Shadow bypass history with the newest entry at index 0.
    logic [3:0]  sh_rd[exu_pkg::BYPASS_DEPTH];
    logic [31:0] sh_data[exu_pkg::BYPASS_DEPTH];
    logic        sh_pend[exu_pkg::BYPASS_DEPTH];

    exu_top DUT (
        .clk             (clk),
        .rst             (rst),
        .idu_valid       (idu_valid),
        .du_to_eu        (du_to_eu),
        .exu_ready       (exu_ready),
        .lsu_ready       (lsu_ready),
        .exu_valid       (exu_valid),
        .eu_to_lu        (eu_to_lu),
        .fence_i_req     (fence_i_req),
        .load_data_valid (load_data_valid),
        .load_data       (load_data),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .pc_update       (pc_update),
        .ebreak_hit      (ebreak_hit)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ////////////////////
    // Instruction builders
    ////////////////////

    function automatic exu_pkg::du_to_eu_t blank();
        exu_pkg::du_to_eu_t d;
        d        = '0;
        d.alu_op = exu_pkg::ALU_ADD;
        return d;
    endfunction

    function automatic exu_pkg::du_to_eu_t op_reg(input exu_pkg::alu_op_e op,
                                                  input logic [3:0] rd, rs1, rs2);
        exu_pkg::du_to_eu_t d;
        d        = blank();
        d.alu_op = op;
        d.rd     = rd;
        d.rs1    = rs1;
        d.rs2    = rs2;
        d.gpr_we = 1'b1;
        return d;
    endfunction

    function automatic exu_pkg::du_to_eu_t op_imm(input exu_pkg::alu_op_e op,
                                                  input logic [3:0] rd, rs1,
                                                  input logic [31:0] imm);
        exu_pkg::du_to_eu_t d;
        d             = op_reg(op, rd, rs1, 4'd0);
        d.imm         = imm;
        d.src2_is_imm = 1'b1;
        return d;
    endfunction

    function automatic exu_pkg::du_to_eu_t load_word(input logic [3:0] rd, rs1,
                                                     input logic [31:0] imm);
        exu_pkg::du_to_eu_t d;
        d           = op_imm(exu_pkg::ALU_ADD, rd, rs1, imm);
        d.is_load   = 1'b1;
        d.load_size = exu_pkg::MEM_WORD;
        return d;
    endfunction

    function automatic exu_pkg::du_to_eu_t branch(input exu_pkg::alu_op_e op,
                                                  input logic [3:0] rs1, rs2,
                                                  input logic [31:0] imm);
        exu_pkg::du_to_eu_t d;
        d             = op_reg(op, 4'd0, rs1, rs2);
        d.gpr_we      = 1'b0;
        d.imm         = imm;
        d.src1_is_pc  = 1'b1;
        d.src2_is_imm = 1'b1;
        d.is_jump     = 1'b1;
        return d;
    endfunction

    function automatic exu_pkg::du_to_eu_t jal(input logic [3:0] rd, input logic [31:0] imm);
        exu_pkg::du_to_eu_t d;
        d            = op_imm(exu_pkg::ALU_ADD, rd, 4'd0, imm);
        d.src1_is_pc = 1'b1;
        d.is_jump    = 1'b1;
        return d;
    endfunction

    function automatic exu_pkg::du_to_eu_t ecall(input logic [31:0] handler);
        exu_pkg::du_to_eu_t d;
        d          = blank();
        d.ecall    = 1'b1;
        d.csr_data = handler;  // Mtvec value.
        return d;
    endfunction

    function automatic exu_pkg::du_to_eu_t csr_op(input logic set, input logic [3:0] rd, rs1,
                                                  input logic [11:0] addr,
                                                  input logic [31:0] old);
        exu_pkg::du_to_eu_t d;
        d          = op_reg(exu_pkg::ALU_ADD, rd, rs1, 4'd0);
        d.imm      = {20'd0, addr};
        d.csrrw_op = ~set;
        d.csrrs_op = set;
        d.csr_data = old;
        return d;
    endfunction

    function automatic exu_pkg::du_to_eu_t side_op(input logic brk, input logic fence);
        exu_pkg::du_to_eu_t d;
        d         = blank();
        d.ebreak  = brk;
        d.fence_i = fence;
        return d;
    endfunction

    task automatic add_row(input exu_pkg::du_to_eu_t instr, input logic valid, fill, pc_upd,
                           input logic e_ready, e_valid, input logic [3:0] e_wen,
                           input logic e_rv, input logic [31:0] e_rpc);
        row_t r;
        r.instr    = instr;
        r.instr.pc = 32'h1000 + 4 * rows.size();
        rng = xorshift32(rng);
        r.instr.src1_r = (instr.rs1 == 0) ? 32'h0 : rng;  // Register file reads x0 as 0.
        rng = xorshift32(rng);
        r.instr.src2_r = (instr.rs2 == 0) ? 32'h0 :
                         (instr.rs2 == instr.rs1) ? r.instr.src1_r : rng;  // Same register.
        rng = xorshift32(rng);
        r.fill_data = rng;
        r.valid     = valid;
        r.fill      = fill;
        r.pc_upd    = pc_upd;
        r.e_ready   = e_ready;
        r.e_valid   = e_valid;
        r.e_wen     = e_wen;
        r.e_rv      = e_rv;
        r.e_rpc     = e_rpc;
        rows.push_back(r);
    endtask

    task automatic build_table();
        `include "tb_exu_vectors.svh"
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic [31:0] ref_alu(input exu_pkg::alu_op_e op, input logic [31:0] a, b);
        case (op)
            exu_pkg::ALU_SUB:    return a - b;
            exu_pkg::ALU_SLL:    return a << b[4:0];
            exu_pkg::ALU_SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exu_pkg::ALU_SLTU:   return (a < b) ? 32'd1 : 32'd0;
            exu_pkg::ALU_XOR:    return a ^ b;
            exu_pkg::ALU_SRL:    return a >> b[4:0];
            exu_pkg::ALU_SRA:    return $unsigned($signed(a) >>> b[4:0]);
            exu_pkg::ALU_OR:     return a | b;
            exu_pkg::ALU_AND:    return a & b;
            exu_pkg::ALU_PASS_B: return b;
            default:             return a + b;  // Add and branch target.
        endcase
    endfunction

    function automatic logic ref_cond(input exu_pkg::alu_op_e op, input logic [31:0] a, b);
        case (op)
            exu_pkg::ALU_EQ:  return a == b;
            exu_pkg::ALU_NE:  return a != b;
            exu_pkg::ALU_LT:  return $signed(a) < $signed(b);
            exu_pkg::ALU_GE:  return $signed(a) >= $signed(b);
            exu_pkg::ALU_LTU: return a < b;
            exu_pkg::ALU_GEU: return a >= b;
            default:          return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] shadow_read(input logic [3:0] rs, input logic [31:0] rf);
        for (int j = 0; j < exu_pkg::BYPASS_DEPTH; j++) begin
            if (rs != 0 && sh_rd[j] == rs) begin
                return sh_data[j];
            end
        end
        return rf;
    endfunction

    task automatic check_val(input string what, input logic [31:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    initial begin
        row_t               r;
        logic [31:0]        s1, s2, a, b, alu, wb, tgt, wdata;
        logic               accept, red_m, take;
        logic               x_valid, x_fence;
        exu_pkg::eu_to_lu_t x_lu;

        clk             = 1'b0;
        rst             = 1'b1;
        idu_valid       = 1'b0;
        du_to_eu        = blank();
        lsu_ready       = 1'b1;
        load_data_valid = 1'b0;
        load_data       = '0;
        pc_update       = 1'b0;
        for (int j = 0; j < exu_pkg::BYPASS_DEPTH; j++) begin
            sh_rd[j]   = '0;
            sh_data[j] = '0;
            sh_pend[j] = 1'b0;
        end
        red_m   = 1'b0;
        x_valid = 1'b0;
        x_fence = 1'b0;
        x_lu    = '0;

        build_table();
        cycle_limit = rows.size() + 5 + 20;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_val("exu_valid after reset", exu_valid, 0);
        check_val("redirect_valid after reset", redirect_valid, 0);
        check_val("fence_i_req after reset", fence_i_req, 0);
        if (eu_to_lu !== '0) begin
            errors++;
            $display("** Error at %0t ns: eu_to_lu is not zero after reset", $time);
        end

        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            idu_valid       = r.valid;
            du_to_eu        = r.instr;
            load_data_valid = r.fill;
            load_data       = r.fill_data;
            pc_update       = r.pc_upd;

            s1     = shadow_read(r.instr.rs1, r.instr.src1_r);
            s2     = shadow_read(r.instr.rs2, r.instr.src2_r);
            a      = r.instr.src1_is_pc ? r.instr.pc : s1;
            b      = r.instr.src2_is_imm ? r.instr.imm : s2;
            alu    = ref_alu(r.instr.alu_op, a, b);
            accept = r.valid && r.e_ready && !red_m;
            if (r.instr.csrrw_op || r.instr.csrrs_op) begin
                wb = r.instr.csr_data;
            end else if (r.instr.is_jump) begin
                wb = r.instr.pc + 4;
            end else begin
                wb = alu;
            end
            tgt   = (r.instr.ecall || r.instr.mret) ? r.instr.csr_data : alu;
            take  = (r.instr.ecall || r.instr.mret ||
                     (r.instr.is_jump && ref_cond(r.instr.alu_op, s1, s2))) &&
                    (tgt != r.instr.pc + 4);
            wdata = r.instr.csrrs_op ? (s1 | r.instr.csr_data) :
                    r.instr.csrrw_op ? s1 : 32'h0;

            #1;
            check_val($sformatf("row %0d exu_ready", i), exu_ready, r.e_ready);
            check_val($sformatf("row %0d ebreak_hit", i), ebreak_hit,
                      r.valid && r.instr.ebreak && !red_m);

            @(posedge clk);
            #1;
            for (int j = 0; j < exu_pkg::BYPASS_DEPTH; j++) begin
                if (r.fill && sh_pend[j]) begin
                    sh_data[j] = r.fill_data;  // Load fill lands.
                    sh_pend[j] = 1'b0;
                end
            end
            if (accept && r.instr.gpr_we) begin
                for (int j = exu_pkg::BYPASS_DEPTH - 1; j > 0; j--) begin
                    sh_rd[j]   = sh_rd[j-1];
                    sh_data[j] = sh_data[j-1];
                    sh_pend[j] = sh_pend[j-1];
                end
                sh_rd[0]   = r.instr.rd;
                sh_data[0] = wb;
                sh_pend[0] = r.instr.is_load;
            end
            if (red_m) begin
                if (r.pc_upd) begin
                    red_m = 1'b0;
                end
            end else if (accept && take) begin
                red_m = 1'b1;
            end
            if (r.e_ready) begin
                x_valid = accept;
                x_fence = accept && r.instr.fence_i;
                x_lu    = '0;
                if (accept) begin
                    x_lu.pc         = r.instr.pc;
                    x_lu.rd         = r.instr.rd;
                    x_lu.gpr_we     = r.instr.gpr_we;
                    x_lu.is_load    = r.instr.is_load;
                    x_lu.is_store   = r.instr.is_store;
                    x_lu.load_size  = r.instr.load_size;
                    x_lu.store_size = r.instr.store_size;
                    x_lu.result     = wb;
                    x_lu.store_data = s2;  // Forwarded rs2.
                    x_lu.csr_wen    = r.e_wen;
                    x_lu.csr_wdata  = wdata;
                    x_lu.ecall      = r.instr.ecall;
                    x_lu.mret       = r.instr.mret;
                end
            end

            check_val($sformatf("row %0d model valid", i), x_valid, r.e_valid);
            check_val($sformatf("row %0d exu_valid", i), exu_valid, r.e_valid);
            check_val($sformatf("row %0d result", i), eu_to_lu.result, x_lu.result);
            check_val($sformatf("row %0d csr_wen", i), eu_to_lu.csr_wen, x_lu.csr_wen);
            check_val($sformatf("row %0d csr_wdata", i), eu_to_lu.csr_wdata, x_lu.csr_wdata);
            checks++;
            if (eu_to_lu !== x_lu) begin
                errors++;
                $display("** Error at %0t ns: row %0d eu_to_lu is %h, expected %h",
                         $time, i, eu_to_lu, x_lu);
            end
            check_val($sformatf("row %0d fence_i_req", i), fence_i_req, x_fence);
            check_val($sformatf("row %0d redirect_valid", i), redirect_valid, r.e_rv);
            check_val($sformatf("row %0d redirect_pc", i), redirect_pc, r.e_rpc);
            @(negedge clk);
        end

        $display("Rows: %0d, checks: %0d, errors: %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
